// ==== common/typec_consts.svh ====
`ifndef TYPEC_CONSTS_SVH
`define TYPEC_CONSTS_SVH

// Transmit buffer entries
`define TYPEC_FIFO_DEPTH 8

// Line value of the bit that follows the lead cycle
`define TYPEC_SYNC_BIT 1'b1

// Idle cycles with fire low before a new frame may start
`define TYPEC_GAP_CYCLES 2

`endif

// ==== common/typec_pkg.sv ====
`default_nettype none

package typec_pkg;

    typedef logic [7:0] byte_t;      // One data byte on the line
    typedef logic [2:0] bit_cnt_t;   // Bit position within a byte
    typedef logic [3:0] fifo_ptr_t;  // Buffer pointer, MSB is the wrap bit

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_LEAD,
        TX_SYNC,
        TX_DATA,
        TX_GAP
    } tx_state_t;

    // RX_BITS with the bit counter covers the eight per-bit states
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_WAIT,
        RX_HUNT,
        RX_BITS,
        RX_DONE
    } rx_state_t;

endpackage

`default_nettype wire

// ==== rtl/typec_tx_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "typec_consts.svh"

module typec_tx_buf
    import typec_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_en,
    input  byte_t wr_data,
    input  logic  pop,
    output byte_t rd_data,
    output logic  empty,
    output logic  full
);

    byte_t     mem [`TYPEC_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      do_wr;
    logic      do_rd;

    // Same index, different wrap bit means the buffer has lapped
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[3] != rd_ptr[3]) && (wr_ptr[2:0] == rd_ptr[2:0]);

    assign do_wr = wr_en && !full;  // Writes while full are lost
    assign do_rd = pop && !empty;

    assign rd_data = mem[rd_ptr[2:0]];  // Head always visible

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 4'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[2:0]] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== typec_txf/typec_txf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "typec_consts.svh"

module typec_txf
    import typec_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  empty,
    input  byte_t rd_data,
    output logic  pop,
    output logic  line_din,
    output logic  line_fire
);

    tx_state_t state;
    byte_t     shreg;
    bit_cnt_t  cnt;
    logic      take_first;
    logic      take_next;

    // A frame starts from idle; a following byte is taken while bit 1 is out
    assign take_first = (state == TX_IDLE) && !empty;
    assign take_next  = (state == TX_DATA) && (cnt == 3'd1) && !empty;
    assign pop        = take_first || take_next;

    // The byte on the line keeps its bit 0 in line_din when the next one loads
    always_ff @(posedge clk) begin
        if (pop) begin
            shreg <= rd_data;
        end
    end

    // State names what the line shows in the current cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= TX_IDLE;
            cnt       <= '0;
            line_din  <= 1'b0;
            line_fire <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (take_first) begin
                        state     <= TX_LEAD;
                        line_fire <= 1'b1;
                        line_din  <= 1'b0;  // Lead cycle
                    end
                end
                TX_LEAD: begin
                    state    <= TX_SYNC;
                    line_din <= `TYPEC_SYNC_BIT;
                end
                TX_SYNC: begin
                    state    <= TX_DATA;
                    cnt      <= 3'd7;
                    line_din <= shreg[7];  // MSB first
                end
                TX_DATA: begin
                    if (cnt != 3'd0) begin
                        cnt      <= cnt - 3'd1;
                        line_din <= shreg[cnt - 3'd1];
                        if ((cnt == 3'd1) && !take_next) begin
                            line_fire <= 1'b0;  // Last bit of the frame
                        end
                    end else if (line_fire) begin
                        // Next byte follows back to back
                        cnt      <= 3'd7;
                        line_din <= shreg[7];
                    end else begin
                        state    <= TX_GAP;
                        line_din <= 1'b0;
                        cnt      <= bit_cnt_t'(`TYPEC_GAP_CYCLES - 1);
                    end
                end
                TX_GAP: begin
                    if (cnt == 3'd0) begin
                        state <= TX_IDLE;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                default: begin
                    state     <= TX_IDLE;
                    line_fire <= 1'b0;
                    line_din  <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== typec_rxf/typec_rxf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "typec_consts.svh"

module typec_rxf
    import typec_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  din,
    input  logic  fire,
    output byte_t dout,
    output logic  byte_valid,
    output logic  frame_end
);

    rx_state_t  state;
    rx_state_t  next_state;
    bit_cnt_t   cnt;
    logic [6:0] hold;
    logic       last_bit;

    assign last_bit = (state == RX_BITS) && (cnt == 3'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RX_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RX_IDLE: next_state = RX_WAIT;
            RX_WAIT: begin
                if (fire) begin
                    next_state = RX_HUNT;
                end
            end
            RX_HUNT: begin
                if (din == `TYPEC_SYNC_BIT) begin
                    next_state = RX_BITS;
                end
            end
            RX_BITS: begin
                if (last_bit && !fire) begin
                    next_state = RX_DONE;  // Fire low on bit 0 ends the frame
                end
            end
            RX_DONE: next_state = RX_WAIT;
            default: next_state = RX_IDLE;
        endcase
    end

    // Counts 7 down to 0 through each byte, restarts while fire holds
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if ((state == RX_HUNT) || last_bit) begin
            cnt <= 3'd7;
        end else if (state == RX_BITS) begin
            cnt <= cnt - 3'd1;
        end
    end

    // First seven bits of a byte, MSB first
    always_ff @(posedge clk) begin
        if ((state == RX_BITS) && !last_bit) begin
            hold <= {hold[5:0], din};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout       <= '0;
            byte_valid <= 1'b0;
            frame_end  <= 1'b0;
        end else begin
            byte_valid <= last_bit;
            frame_end  <= (state == RX_DONE);
            if (last_bit) begin
                dout <= {hold, din};  // Eighth bit taken straight off the line
            end else if ((state == RX_IDLE) || (state == RX_DONE)) begin
                dout <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/typec_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module typec_link
    import typec_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_en,
    input  byte_t wr_data,
    output logic  full,
    output logic  line_din,
    output logic  line_fire,
    output byte_t rx_data,
    output logic  rx_valid,
    output logic  rx_end
);

    byte_t buf_data;
    logic  buf_empty;
    logic  buf_pop;

    typec_tx_buf u_tx_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .pop     (buf_pop),
        .rd_data (buf_data),
        .empty   (buf_empty),
        .full    (full)
    );

    typec_txf u_txf (
        .clk       (clk),
        .rst       (rst),
        .empty     (buf_empty),
        .rd_data   (buf_data),
        .pop       (buf_pop),
        .line_din  (line_din),
        .line_fire (line_fire)
    );

    // Loopback, the line is also exported for observation
    typec_rxf u_rxf (
        .clk        (clk),
        .rst        (rst),
        .din        (line_din),
        .fire       (line_fire),
        .dout       (rx_data),
        .byte_valid (rx_valid),
        .frame_end  (rx_end)
    );

endmodule

`default_nettype wire

// ==== tb/typec_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module typec_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
    end

    always #2 clk = ~clk;  // 4 ns period

    initial begin
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/typec_link_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "typec_consts.svh"

module typec_link_sva (
    input logic clk,
    input logic rst,
    input logic line_fire,
    input logic rx_valid,
    input logic rx_end,
    input logic full
);

    int fail_count = 0;  // Failed assertion attempts so far

    // A byte strobe and the end pulse never share a cycle
    property valid_end_apart;
        @(posedge clk) disable iff (rst)
            !(rx_valid && rx_end);
    endproperty

    // Fire stays low for the minimum gap once a frame has ended
    property gap_after_frame;
        @(posedge clk) disable iff (rst)
            $fell(line_fire) |-> !line_fire [*`TYPEC_GAP_CYCLES];
    endproperty

    // Frames of up to eight bytes never fill the buffer
    property buffer_never_full;
        @(posedge clk) disable iff (rst)
            !$rose(full);
    endproperty

    valid_end_apart_a: assert property (valid_end_apart)
        else begin
            fail_count++;
            $error("rx_valid and rx_end high in the same cycle");
        end

    gap_after_frame_a: assert property (gap_after_frame)
        else begin
            fail_count++;
            $error("line_fire rose again before the inter-frame gap ended");
        end

    buffer_never_full_a: assert property (buffer_never_full)
        else begin
            fail_count++;
            $error("transmit buffer became full");
        end

endmodule

bind typec_link typec_link_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .line_fire (line_fire),
    .rx_valid  (rx_valid),
    .rx_end    (rx_end),
    .full      (full)
);

`default_nettype wire

// ==== tb/typec_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "typec_consts.svh"

module typec_link_tb
    import typec_pkg::*;
;

    localparam int NUM_FRAMES = 7;
    localparam int FIRST_LATENCY = 10;  // Lead cycle to first byte strobe

    // Frame lengths and the fire length each one should produce
    int frame_len [NUM_FRAMES] = '{1, 2, 3, 8, 5, 1, 4};
    int fire_cycles [NUM_FRAMES] = '{9, 17, 25, 65, 41, 9, 33};

    logic  clk;
    logic  rst;
    logic  wr_en;
    byte_t wr_data;
    logic  full;
    logic  line_din;
    logic  line_fire;
    byte_t rx_data;
    logic  rx_valid;
    logic  rx_end;

    byte_t  exp_q [$];    // Bytes written, not yet received
    int     frame_q [$];  // Frames written, line not yet started
    integer seed;
    integer rnd;
    int     limit;
    int     cyc = 0;
    int     ends_seen = 0;
    int     cur_frame = 0;
    int     fire_start = 0;
    int     fire_len = 0;
    int     low_len = 0;
    int     rx_count = 0;
    int     last_valid_cyc = 0;
    logic   prev_fire = 1'b0;
    logic   seen_frame = 1'b0;
    logic   after_end = 1'b1;  // rx_data must read zero until a byte lands

    typec_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    typec_link DUT (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .full      (full),
        .line_din  (line_din),
        .line_fire (line_fire),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_end    (rx_end)
    );

    task automatic expect_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("[FAIL] t=%0t %s = %0d, expected %0d", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic expect_cond(input logic ok, input string what);
        assert (ok) else begin
            $display("Error at t=%0t: %s", $time, what);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("Timeout: test did not finish within %0d cycles", limit);
            $display("Checks failed");
            $fatal(1);
        end
    end

    // Line and receiver monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            expect_value("line_fire", line_fire, 0);
            expect_value("line_din", line_din, 0);
            expect_value("rx_valid", rx_valid, 0);
            expect_value("rx_end", rx_end, 0);
            expect_value("rx_data", rx_data, 0);
            expect_value("full", full, 0);
        end else begin
            if (line_fire && !prev_fire) begin
                expect_cond(frame_q.size() != 0, "line_fire rose with no frame written");
                if (seen_frame) begin
                    expect_cond(low_len >= `TYPEC_GAP_CYCLES, "inter-frame gap too short");
                end
                cur_frame = frame_q.pop_front();
                seen_frame = 1'b1;
                fire_start = cyc;
                fire_len = 0;
                rx_count = 0;
            end
            if (line_fire) begin
                fire_len++;
                low_len = 0;
                if (fire_len == 1) begin
                    expect_value("line_din (lead)", line_din, 0);
                end else if (fire_len == 2) begin
                    expect_value("line_din (sync)", line_din, 1);
                end
            end else begin
                low_len++;
            end
            if (!line_fire && prev_fire) begin
                expect_value("line_fire high cycles", fire_len, fire_cycles[cur_frame]);
            end
            if (rx_valid) begin
                expect_cond(exp_q.size() != 0, "rx_valid with no byte left to receive");
                expect_value("rx_data", rx_data, exp_q.pop_front());
                expect_value("rx_valid delay", cyc - fire_start,
                             FIRST_LATENCY + 8 * rx_count);
                rx_count++;
                last_valid_cyc = cyc;
                after_end = 1'b0;
            end
            if (rx_end) begin
                expect_cond(!rx_valid, "rx_end and rx_valid in the same cycle");
                expect_value("rx_end delay", cyc - last_valid_cyc, 1);
                expect_value("bytes in frame", rx_count, frame_len[cur_frame]);
                ends_seen++;
                after_end = 1'b1;
            end
            if (after_end) begin
                expect_value("rx_data after frame end", rx_data, 0);
            end
            expect_value("full", full, 0);
        end
        expect_cond(DUT.u_sva.fail_count == 0, "a bound assertion on the DUT failed");
        prev_fire = line_fire;
    end

    initial begin
        wr_en   = 1'b0;
        wr_data = '0;
        seed    = 32'h6c3a;
        limit   = 100;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            limit += 20 * frame_len[f] + 40;
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            expect_cond(frame_len[f] <= `TYPEC_FIFO_DEPTH, "frame longer than buffer");
        end

        @(negedge rst);
        repeat (3) @(posedge clk);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            frame_q.push_back(f);
            for (int b = 0; b < frame_len[f]; b++) begin
                @(posedge clk);
                rnd = $random(seed);
                wr_en   <= 1'b1;
                wr_data <= rnd[7:0];
                exp_q.push_back(rnd[7:0]);
            end
            @(posedge clk);
            wr_en   <= 1'b0;
            wr_data <= '0;
            while (ends_seen <= f) begin
                @(posedge clk);
            end
        end

        repeat (4) @(posedge clk);
        expect_value("bytes left unreceived", exp_q.size(), 0);
        expect_value("frames left unsent", frame_q.size(), 0);
        expect_value("frame ends seen", ends_seen, NUM_FRAMES);
        expect_cond(DUT.u_sva.fail_count == 0, "a bound assertion on the DUT failed");
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== typec_link.f ====
+incdir+common
common/typec_pkg.sv
rtl/typec_tx_buf.sv
typec_txf/typec_txf.sv
typec_rxf/typec_rxf.sv
rtl/typec_link.sv
tb/typec_clk_gen.sv
tb/typec_link_sva.sv
tb/typec_link_tb.sv
